// File: dll_code_ctrl.f
dll_cfg_pkg.sv
dll_ctrl_pkg.sv
dll_lock_fsm.sv
dll_code_counter.sv
half_cycle_code_gen.sv
dll_code_ctrl.sv
tb_dll_code_ctrl.sv

// File: tb_dll_code_ctrl.sv
`timescale 1ns/1ps

module tb_dll_code_ctrl;

  import dll_cfg_pkg::*;

  // ----------------------------------------
  // run setup
  // ----------------------------------------
  localparam int                FILTER_LEN   = FILTER_LEN_DEF;
  localparam int                LOCK_TOGGLES = LOCK_TOGGLES_DEF;
  localparam logic [CODE_W-1:0] CODE_INIT    = CODE_INIT_DEF;

  localparam int CLK_PERIOD  = 4;
  localparam int WIN_CYC     = FILTER_LEN + 1;  // vote window plus the strobe
  localparam int LOCK_BOUND  = ((1 << COARSE_W) + 4 * LOCK_TOGGLES) * WIN_CYC;
  localparam int HOLD_CYC    = 8 * WIN_CYC;     // code watched against the target
  localparam int OVR_CYC     = 4 * WIN_CYC;     // long enough for strobes to hit
  localparam int DIS_CYC     = 4;
  localparam int N_FIXED     = 9;
  localparam int N_RAND      = 4;
  localparam int N_ENTRIES   = N_FIXED + N_RAND;
  localparam int ENTRY_CYC   = LOCK_BOUND + HOLD_CYC + DIS_CYC + 4;
  localparam int WATCHDOG_NS = (N_ENTRIES * ENTRY_CYC + 16) * CLK_PERIOD;

  typedef enum logic {KIND_LOCK, KIND_FORCED} kind_e;  // loop locks, or code is forced

  typedef struct packed {
    logic [CODE_W-1:0] target;    // phase detector crossover
    logic [CODE_W-1:0] ovr_val;
    logic              ovr_en;
    logic              half_sel;  // start value, toggled at random later
    kind_e             kind;
  } entry_t;

  entry_t tbl [N_ENTRIES];
  int     n_loaded   = 0;
  int     n_checks   = 0;
  int     n_mismatch = 0;
  int     n_fail     = 0;

  logic              clk = 1'b0;
  logic              reset_n;
  logic              dll_en;
  logic              phase_early;
  logic              rb_code_override_en;
  logic [CODE_W-1:0] rb_code_override;
  logic              rb_half_code;
  logic [CODE_W-1:0] pvt_ref_binary;
  logic [CODE_W-1:0] pvt_ref_half_binary;
  logic              dll_lock;
  logic [CODE_W-1:0] target;  // crossover of the modeled delay line

  dll_code_ctrl #(
    .FILTER_LEN   (FILTER_LEN),
    .LOCK_TOGGLES (LOCK_TOGGLES),
    .CODE_INIT    (CODE_INIT)
  ) i_dll_code_ctrl (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dll_en              (dll_en),
    .phase_early         (phase_early),
    .rb_code_override_en (rb_code_override_en),
    .rb_code_override    (rb_code_override),
    .rb_half_code        (rb_half_code),
    .pvt_ref_binary      (pvt_ref_binary),
    .pvt_ref_half_binary (pvt_ref_half_binary),
    .dll_lock            (dll_lock)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // phase detector, early while the chain is shorter than the target
  always @(posedge clk) begin
    phase_early <= (pvt_ref_binary < target);
  end

  // ----------------------------------------
  // compare and reference model
  // ----------------------------------------
  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual, input int tol);
    int diff;
    diff = int'(expected) - int'(actual);
    if (diff < 0) diff = -diff;
    n_checks++;
    if ($isunknown(actual) || diff > tol) begin
      n_mismatch++;
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  // shift right, round odd codes up unless the low field is already full
  function automatic logic [CODE_W-1:0] half_code_of(input logic [CODE_W-1:0] code);
    logic [CODE_W-1:0] half;
    half = code >> 1;
    if (code[0] && (half[FINE_W-1:0] != '1)) half = half + 1'b1;
    return half;
  endfunction

  // ----------------------------------------
  // per-cycle checks on stable outputs
  // ----------------------------------------
  logic              prev_rst_n = 1'b0;
  logic [CODE_W-1:0] prev_code;
  logic              prev_half_sel;
  logic              prev_ovr_en;
  logic [CODE_W-1:0] prev_ovr_val;

  always @(negedge clk) begin
    if (!reset_n) begin
      compare("dll_lock", 0, dll_lock, 0);
      compare("pvt_ref_half_binary", 0, pvt_ref_half_binary, 0);
      compare("pvt_ref_binary", CODE_INIT, pvt_ref_binary, 0);
    end else if (prev_rst_n) begin
      if (prev_half_sel) begin
        compare("pvt_ref_half_binary", half_code_of(prev_code), pvt_ref_half_binary, 0);
      end else begin
        compare("pvt_ref_half_binary", prev_code, pvt_ref_half_binary, 0);  // pass-through
      end
      if (prev_ovr_en) compare("pvt_ref_binary", prev_ovr_val, pvt_ref_binary, 0);
    end
    prev_rst_n    = reset_n;
    prev_code     = pvt_ref_binary;
    prev_half_sel = rb_half_code;  // value the dut takes at the coming edge
    prev_ovr_en   = rb_code_override_en;
    prev_ovr_val  = rb_code_override;
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic add_entry(input logic [CODE_W-1:0] tgt, input logic [CODE_W-1:0] ovr_val,
                           input logic ovr_en, input logic half_sel, input kind_e kind);
    tbl[n_loaded].target   = tgt;
    tbl[n_loaded].ovr_val  = ovr_val;
    tbl[n_loaded].ovr_en   = ovr_en;
    tbl[n_loaded].half_sel = half_sel;
    tbl[n_loaded].kind     = kind;
    n_loaded++;
  endtask

  task automatic load_table();
    add_entry(11'd0,    11'd0,     1'b0, 1'b0, KIND_LOCK);    // floor, starting at floor
    add_entry(11'd2047, 11'd0,     1'b0, 1'b1, KIND_LOCK);    // ceiling
    add_entry(11'd127,  11'd0,     1'b0, 1'b1, KIND_LOCK);    // fine field 7
    add_entry(11'd333,  11'd0,     1'b0, 1'b0, KIND_LOCK);    // odd
    add_entry(11'd0,    11'h7ff,   1'b1, 1'b1, KIND_FORCED);  // loop pulls down
    add_entry(11'd1023, 11'd0,     1'b0, 1'b1, KIND_LOCK);
    add_entry(11'd2047, 11'h005,   1'b1, 1'b0, KIND_FORCED);  // loop pulls up
    add_entry(11'd0,    11'd0,     1'b0, 1'b1, KIND_LOCK);
    add_entry(11'd2046, 11'd0,     1'b0, 1'b0, KIND_LOCK);
    for (int i = N_FIXED; i < N_ENTRIES; i++) begin
      add_entry(CODE_W'($urandom), '0, 1'b0, 1'($urandom), KIND_LOCK);
    end
  endtask

  // one clock, half-select toggled now and then
  task automatic tick(input logic near_check);
    @(posedge clk);
    if (($urandom % 16) == 0) rb_half_code <= ~rb_half_code;
    @(negedge clk);
    if (near_check) begin
      compare("pvt_ref_binary", target, pvt_ref_binary, 1);  // within one step
      compare("dll_lock", 1, dll_lock, 0);
    end
  endtask

  task automatic drop_enable();
    logic [CODE_W-1:0] held;
    @(posedge clk);
    dll_en              <= 1'b0;
    rb_code_override_en <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare("dll_lock", 0, dll_lock, 0);
    held = pvt_ref_binary;  // a last strobe may still land on this edge
    repeat (DIS_CYC) begin
      @(negedge clk);
      compare("pvt_ref_binary", held, pvt_ref_binary, 0);
    end
  endtask

  task automatic run_lock_entry(input int idx);
    int cyc;
    @(posedge clk);
    target       <= tbl[idx].target;
    rb_half_code <= tbl[idx].half_sel;
    dll_en       <= 1'b1;
    cyc = 0;
    @(negedge clk);
    while (!dll_lock && cyc < LOCK_BOUND) begin
      tick(1'b0);
      cyc++;
    end
    if (!dll_lock) begin
      n_fail++;
      $display("dll_lock did not rise within %0d cycles for target %0d",
               LOCK_BOUND, tbl[idx].target);
    end else begin
      repeat (HOLD_CYC) tick(1'b1);
    end
    drop_enable();
  endtask

  task automatic run_forced_entry(input int idx);
    @(posedge clk);
    target              <= tbl[idx].target;
    rb_half_code        <= tbl[idx].half_sel;
    rb_code_override    <= tbl[idx].ovr_val;
    rb_code_override_en <= tbl[idx].ovr_en;
    dll_en              <= 1'b1;  // loop keeps stepping underneath
    repeat (OVR_CYC) tick(1'b0);
    compare("pvt_ref_binary", tbl[idx].ovr_val, pvt_ref_binary, 0);
    drop_enable();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int seed_val;
    reset_n             = 1'b0;
    dll_en              = 1'b0;
    phase_early         = 1'b0;
    rb_code_override_en = 1'b0;
    rb_code_override    = '0;
    rb_half_code        = 1'b0;
    target              = '0;
    seed_val = $urandom(32'h95d5);
    load_table();
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    compare("dll_lock", 0, dll_lock, 0);
    compare("pvt_ref_binary", CODE_INIT, pvt_ref_binary, 0);
    compare("pvt_ref_half_binary", 0, pvt_ref_half_binary, 0);
    for (int idx = 0; idx < N_ENTRIES; idx++) begin
      if (tbl[idx].kind == KIND_LOCK) run_lock_entry(idx);
      else run_forced_entry(idx);
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, mismatches %0d, other failures %0d", n_checks, n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // bound from table length and worst-case lock time per entry
  initial begin
    #(WATCHDOG_NS);
    $display("run timed out after %0t, the table never completed", $time);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: dll_code_ctrl.sv
`timescale 1ns/1ps

module dll_code_ctrl #(
  parameter int                             FILTER_LEN   = dll_cfg_pkg::FILTER_LEN_DEF,
  parameter int                             LOCK_TOGGLES = dll_cfg_pkg::LOCK_TOGGLES_DEF,
  parameter logic [dll_cfg_pkg::CODE_W-1:0] CODE_INIT    = dll_cfg_pkg::CODE_INIT_DEF
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           dll_en,
  input  logic                           phase_early,          // from the phase detector
  input  logic                           rb_code_override_en,
  input  logic [dll_cfg_pkg::CODE_W-1:0] rb_code_override,
  input  logic                           rb_half_code,
  output logic [dll_cfg_pkg::CODE_W-1:0] pvt_ref_binary,       // full cycle code
  output logic [dll_cfg_pkg::CODE_W-1:0] pvt_ref_half_binary,  // half cycle code
  output logic                           dll_lock
);

  import dll_ctrl_pkg::*;

  // ----------------------------------------
  // fsm to counter
  // ----------------------------------------
  step_e step_cmd;     // one-cycle step strobe
  logic  step_coarse;  // coarse step size while searching

  dll_lock_fsm #(
    .FILTER_LEN   (FILTER_LEN),
    .LOCK_TOGGLES (LOCK_TOGGLES)
  ) i_dll_lock_fsm (
    .clk         (clk),
    .reset_n     (reset_n),
    .dll_en      (dll_en),
    .phase_early (phase_early),
    .step_cmd    (step_cmd),
    .step_coarse (step_coarse),
    .dll_lock    (dll_lock)
  );

  dll_code_counter #(
    .CODE_INIT (CODE_INIT)
  ) i_dll_code_counter (
    .clk                 (clk),
    .reset_n             (reset_n),
    .step_cmd            (step_cmd),
    .step_coarse         (step_coarse),
    .rb_code_override_en (rb_code_override_en),
    .rb_code_override    (rb_code_override),
    .pvt_ref_binary      (pvt_ref_binary)
  );

  // half code follows the full code one cycle later
  half_cycle_code_gen i_half_cycle_code_gen (
    .clk                 (clk),
    .reset_n             (reset_n),
    .pvt_ref_binary      (pvt_ref_binary),
    .rb_half_code        (rb_half_code),
    .pvt_ref_half_binary (pvt_ref_half_binary)
  );

endmodule

// File: half_cycle_code_gen.sv
`timescale 1ns/1ps

module half_cycle_code_gen (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic [dll_cfg_pkg::CODE_W-1:0] pvt_ref_binary,      // full cycle code
  input  logic                           rb_half_code,        // 1 selects the half code
  output logic [dll_cfg_pkg::CODE_W-1:0] pvt_ref_half_binary  // to the second delay chain
);

  import dll_cfg_pkg::*;

  logic [COARSE_W-1:0] coarse_in;
  logic [COARSE_W-1:0] coarse_half;
  logic [FINE_W-1:0]   fine_in;
  logic [FINE_W-1:0]   fine_half;
  logic [FINE_W-1:0]   fine_rnd;

  // ----------------------------------------
  // split and halve
  // ----------------------------------------
  assign coarse_in   = pvt_ref_binary[CODE_W-1 -: COARSE_W];
  assign fine_in     = pvt_ref_binary[FINE_W-1:0];
  assign coarse_half = coarse_in >> 1;

  // coarse lsb shifted out lands in the fine msb, weight of four
  assign fine_half = {coarse_in[0], fine_in[FINE_W-1:1]};

  // round up an odd code, fine field never wraps into coarse
  assign fine_rnd = (fine_in[0] && (fine_half != '1)) ? fine_half + 1'b1 : fine_half;

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pvt_ref_half_binary <= '0;
    end else if (rb_half_code) begin
      pvt_ref_half_binary <= {coarse_half, fine_rnd};
    end else begin
      pvt_ref_half_binary <= pvt_ref_binary;  // full code passed through
    end
  end

endmodule

// File: dll_code_counter.sv
`timescale 1ns/1ps

module dll_code_counter #(
  parameter logic [dll_cfg_pkg::CODE_W-1:0] CODE_INIT = dll_cfg_pkg::CODE_INIT_DEF
) (
  input  logic                             clk,
  input  logic                             reset_n,
  input  dll_ctrl_pkg::step_e              step_cmd,             // strobe from the lock FSM
  input  logic                             step_coarse,          // 8 instead of 1
  input  logic                             rb_code_override_en,  // register bank override
  input  logic [dll_cfg_pkg::CODE_W-1:0]   rb_code_override,
  output logic [dll_cfg_pkg::CODE_W-1:0]   pvt_ref_binary        // code to the delay chain
);

  import dll_cfg_pkg::*;
  import dll_ctrl_pkg::*;

  localparam logic [CODE_W-1:0] CODE_MAX = '1;  // top of the chain, 2047

  logic [CODE_W-1:0] step_size;
  logic [CODE_W-1:0] code_nxt;

  // ----------------------------------------
  // step size and clamped next code
  // ----------------------------------------
  assign step_size = step_coarse ? CODE_W'(COARSE_STEP) : CODE_W'(1);

  always_comb begin
    case (step_cmd)
      STEP_UP: begin
        // clamp when the headroom is smaller than the step
        if ((CODE_MAX - pvt_ref_binary) < step_size) begin
          code_nxt = CODE_MAX;
        end else begin
          code_nxt = pvt_ref_binary + step_size;
        end
      end
      STEP_DN: begin
        if (pvt_ref_binary < step_size) begin
          code_nxt = '0;  // floor of the chain
        end else begin
          code_nxt = pvt_ref_binary - step_size;
        end
      end
      STEP_NONE: code_nxt = pvt_ref_binary;
      default:   code_nxt = pvt_ref_binary;
    endcase
  end

  // ----------------------------------------
  // code register, override wins over steps
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pvt_ref_binary <= CODE_INIT;
    end else if (rb_code_override_en) begin
      pvt_ref_binary <= rb_code_override;  // forced code, steps dropped
    end else begin
      pvt_ref_binary <= code_nxt;
    end
  end

endmodule

// File: dll_lock_fsm.sv
`timescale 1ns/1ps

module dll_lock_fsm #(
  parameter int FILTER_LEN   = dll_cfg_pkg::FILTER_LEN_DEF,
  parameter int LOCK_TOGGLES = dll_cfg_pkg::LOCK_TOGGLES_DEF
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                dll_en,       // loop enable, level
  input  logic                phase_early,  // delay too short, code must go up
  output dll_ctrl_pkg::step_e step_cmd,     // one-cycle strobe
  output logic                step_coarse,  // step size 8 while searching
  output logic                dll_lock
);

  import dll_cfg_pkg::*;
  import dll_ctrl_pkg::*;

  // ----------------------------------------
  // widths and limits
  // ----------------------------------------
  localparam int SMP_W = $clog2(FILTER_LEN + 1);    // holds 0..FILTER_LEN
  localparam int TGL_W = $clog2(LOCK_TOGGLES + 1);
  localparam int RUN_W = COARSE_W + 1;              // holds a full coarse sweep

  localparam logic [SMP_W-1:0] WIN_LAST = SMP_W'(FILTER_LEN - 1);
  localparam logic [SMP_W:0]   WIN_LEN  = (SMP_W + 1)'(FILTER_LEN);
  localparam logic [TGL_W-1:0] TGL_LAST = TGL_W'(LOCK_TOGGLES - 1);

  // a same-direction run as long as a full sweep means the code sits on a rail
  localparam logic [RUN_W-1:0] RUN_MAX  = RUN_W'(1 << COARSE_W);
  localparam logic [RUN_W-1:0] RUN_FINE = RUN_W'(COARSE_STEP);

  lock_state_e      state, state_nxt;
  logic [SMP_W-1:0] smp_cnt;     // position inside the vote window
  logic [SMP_W-1:0] early_cnt;   // early samples so far in the window
  logic [SMP_W-1:0] early_tot;   // tally including this cycle's sample
  logic             win_done;
  step_e            vote;
  step_e            last_step;   // direction of the previous real step
  logic             new_step;
  logic             reversal;
  logic             same_dir;
  logic [RUN_W-1:0] run_cnt, run_nxt;
  logic             pinned_coarse;
  logic             pinned_fine;
  logic             settle;      // event counted towards lock
  logic [TGL_W-1:0] tgl_cnt;

  // ----------------------------------------
  // majority vote over one window
  // ----------------------------------------
  assign win_done  = (smp_cnt == WIN_LAST);
  assign early_tot = early_cnt + SMP_W'(phase_early);

  always_comb begin
    if ({early_tot, 1'b0} > WIN_LEN) begin
      vote = STEP_UP;    // more than half early
    end else if ({early_tot, 1'b0} < WIN_LEN) begin
      vote = STEP_DN;    // more than half late
    end else begin
      vote = STEP_NONE;  // tie, hold
    end
  end

  assign new_step = win_done && (vote != STEP_NONE);
  assign reversal = new_step && (last_step != STEP_NONE) && (vote != last_step);
  assign same_dir = new_step && (vote == last_step);

  // run length of steps in one direction, saturating
  always_comb begin
    run_nxt = run_cnt;
    if (reversal || (new_step && last_step == STEP_NONE)) begin
      run_nxt = RUN_W'(1);
    end else if (same_dir && run_cnt != RUN_MAX) begin
      run_nxt = run_cnt + 1'b1;
    end
  end

  assign pinned_coarse = same_dir && (run_cnt == RUN_MAX);
  assign pinned_fine   = same_dir && (run_cnt >= RUN_FINE);  // past a coarse cell of fine steps
  assign settle        = reversal || pinned_fine;

  // ----------------------------------------
  // search / track / lock
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:   state_nxt = SEARCH;  // enable seen
      SEARCH: begin
        if (reversal || pinned_coarse) state_nxt = TRACK;
      end
      TRACK:  begin
        if (settle && tgl_cnt == TGL_LAST) state_nxt = LOCKED;
      end
      LOCKED: state_nxt = LOCKED;  // left only through dll_en
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      step_cmd  <= STEP_NONE;
      smp_cnt   <= '0;
      early_cnt <= '0;
      last_step <= STEP_NONE;
      run_cnt   <= '0;
      tgl_cnt   <= '0;
    end else if (!dll_en) begin
      // back to idle, window restarts on the next enable
      state     <= IDLE;
      step_cmd  <= STEP_NONE;
      smp_cnt   <= '0;
      early_cnt <= '0;
      last_step <= STEP_NONE;
      run_cnt   <= '0;
      tgl_cnt   <= '0;
    end else begin
      state    <= state_nxt;
      step_cmd <= win_done ? vote : STEP_NONE;  // strobe in the cycle after the window
      if (win_done) begin
        smp_cnt   <= '0;
        early_cnt <= '0;
      end else begin
        smp_cnt   <= smp_cnt + 1'b1;
        early_cnt <= early_tot;
      end
      if (new_step) last_step <= vote;
      run_cnt <= run_nxt;
      if (state == SEARCH) begin
        tgl_cnt <= '0;
      end else if (state == TRACK && settle) begin
        tgl_cnt <= tgl_cnt + 1'b1;
      end
    end
  end

  assign step_coarse = (state == SEARCH);
  assign dll_lock    = (state == LOCKED);

endmodule

// File: dll_ctrl_pkg.sv
package dll_ctrl_pkg;

  // ----------------------------------------
  // lock machine states
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // loop disabled, code frozen
    SEARCH = 2'd1,  // coarse steps until the phase flips
    TRACK  = 2'd2,  // fine steps, counting reversals
    LOCKED = 2'd3   // lock flagged, still tracking fine
  } lock_state_e;

  // ----------------------------------------
  // step command towards the code register
  // ----------------------------------------
  typedef enum logic [1:0] {
    STEP_NONE = 2'd0,  // hold the code
    STEP_UP   = 2'd1,  // more delay
    STEP_DN   = 2'd2   // less delay
  } step_e;

endpackage

// File: dll_cfg_pkg.sv
package dll_cfg_pkg;

  // ----------------------------------------
  // delay code layout
  // ----------------------------------------
  localparam int CODE_W   = 11;  // full code driven to the delay chain
  localparam int COARSE_W = 8;   // upper bits, one coarse cell each
  localparam int FINE_W   = 3;   // lower bits, interpolator taps

  // one coarse unit expressed in fine units
  localparam int COARSE_STEP = 1 << FINE_W;

  // ----------------------------------------
  // default tuning of the loop
  // ----------------------------------------
  localparam int FILTER_LEN_DEF   = 4;  // phase samples per vote window
  localparam int LOCK_TOGGLES_DEF = 4;  // reversals in track before lock

  // code loaded at reset, bottom of the chain
  localparam logic [CODE_W-1:0] CODE_INIT_DEF = '0;

endpackage
